// File: hdl/cp0_pkg.sv
package cp0_pkg;

    // --------------------
    // basic types
    // --------------------
    // register / data word
    typedef logic [31:0] cp0_word_t;
    // {reg number, select}
    typedef logic [7:0] cp0_addr_t;
    typedef logic [4:0] exc_code_t;

    // --------------------
    // register addresses
    // --------------------
    // reg 8 sel 0
    localparam cp0_addr_t ADDR_BADVADDR = 8'd64;
    // reg 9 sel 0
    localparam cp0_addr_t ADDR_COUNT    = 8'd72;
    // reg 11 sel 0
    localparam cp0_addr_t ADDR_COMPARE  = 8'd88;
    // reg 12 sel 0
    localparam cp0_addr_t ADDR_STATUS   = 8'd96;
    // reg 13 sel 0
    localparam cp0_addr_t ADDR_CAUSE    = 8'd104;
    // reg 14 sel 0
    localparam cp0_addr_t ADDR_EPC      = 8'd112;

    // --------------------
    // field positions
    // --------------------
    // status
    localparam int STATUS_IE    = 0;
    localparam int STATUS_EXL   = 1;
    localparam int STATUS_IM_LO = 8;
    localparam int STATUS_IM_HI = 15;
    localparam int STATUS_BEV   = 22;

    // cause
    localparam int CAUSE_EXC_LO = 2;
    localparam int CAUSE_EXC_HI = 6;
    localparam int CAUSE_IP_LO  = 8;
    localparam int CAUSE_IP_HI  = 15;
    localparam int CAUSE_TI     = 30;
    localparam int CAUSE_BD     = 31;

    // --------------------
    // exception codes
    // --------------------
    localparam exc_code_t EXC_INT  = 5'd0;
    // address error on load / fetch
    localparam exc_code_t EXC_ADEL = 5'd4;
    // address error on store
    localparam exc_code_t EXC_ADES = 5'd5;

    // boot exception vector, BEV=1 only
    localparam cp0_word_t EXC_VECTOR = 32'hbfc0_0380;

    // mftc0 op encodings, bit 1 marks a write
    localparam logic [1:0] MFTC0_MTC0 = 2'b10;
    localparam logic [1:0] MFTC0_MFC0 = 2'b01;

endpackage

// File: hdl/cp0_timer.sv
`timescale 1ns/100ps

module cp0_timer (
    input  logic                clk,
    input  logic                rst,
    input  logic                mtc0_we,
    input  cp0_pkg::cp0_addr_t  cp0_addr,
    input  cp0_pkg::cp0_word_t  mtc0_data,
    output cp0_pkg::cp0_word_t  count,
    output cp0_pkg::cp0_word_t  compare,
    output logic                timer_int
);

    // half-rate phase for count
    logic tick;
    logic wr_count;
    logic wr_compare;

    // address decode for mtc0
    assign wr_count   = mtc0_we && (cp0_addr == cp0_pkg::ADDR_COUNT);
    assign wr_compare = mtc0_we && (cp0_addr == cp0_pkg::ADDR_COMPARE);

    // --------------------
    // count
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (wr_count) begin
            // load restarts the half-rate phase
            count <= mtc0_data;
            tick  <= 1'b0;
        end else begin
            tick <= ~tick;
            // bump on every second edge
            if (tick) begin
                count <= count + 32'd1;
            end
        end
    end

    // --------------------
    // compare, timer irq
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            compare   <= '0;
            timer_int <= 1'b0;
        end else if (wr_compare) begin
            // writing compare acks the timer
            compare   <= mtc0_data;
            timer_int <= 1'b0;
        end else if ((count == compare) && (compare != '0)) begin
            // sticky until next compare write
            timer_int <= 1'b1;
        end
    end

endmodule

// File: hdl/cp0_regs.sv
`timescale 1ns/100ps

module cp0_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                exc_take,
    input  cp0_pkg::exc_code_t  exc_code_eff,
    input  logic                eret_take,
    input  logic                mtc0_we,
    input  logic                bd,
    input  cp0_pkg::cp0_word_t  pc,
    input  cp0_pkg::cp0_word_t  bad_vaddr,
    input  cp0_pkg::cp0_addr_t  cp0_addr,
    input  cp0_pkg::cp0_word_t  mtc0_data,
    input  logic [5:0]          ext_int,
    input  logic                timer_int,
    input  cp0_pkg::cp0_word_t  count,
    input  cp0_pkg::cp0_word_t  compare,
    output logic                status_ie,
    output logic                status_exl,
    output logic [7:0]          status_im,
    output logic [7:0]          cause_ip,
    output cp0_pkg::cp0_word_t  epc,
    output cp0_pkg::cp0_word_t  rd_data
);

    // cause state
    logic [5:0]          ip_hw;
    logic [1:0]          ip_sw;
    logic                cause_bd;
    cp0_pkg::exc_code_t  cause_exc;

    cp0_pkg::cp0_word_t  badvaddr;

    // assembled views for mfc0
    cp0_pkg::cp0_word_t  status_word;
    cp0_pkg::cp0_word_t  cause_word;

    logic wr_status;
    logic wr_cause;
    logic wr_epc;
    logic addr_err;

    assign wr_status = mtc0_we && (cp0_addr == cp0_pkg::ADDR_STATUS);
    assign wr_cause  = mtc0_we && (cp0_addr == cp0_pkg::ADDR_CAUSE);
    assign wr_epc    = mtc0_we && (cp0_addr == cp0_pkg::ADDR_EPC);

    // badvaddr only latched on address errors
    assign addr_err = (exc_code_eff == cp0_pkg::EXC_ADEL) ||
                      (exc_code_eff == cp0_pkg::EXC_ADES);

    // --------------------
    // status
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            status_ie  <= 1'b0;
            status_exl <= 1'b0;
            status_im  <= '0;
        end else if (exc_take) begin
            status_exl <= 1'b1;
        end else begin
            // only IM, EXL and IE are writable
            if (wr_status) begin
                status_ie  <= mtc0_data[cp0_pkg::STATUS_IE];
                status_exl <= mtc0_data[cp0_pkg::STATUS_EXL];
                status_im  <= mtc0_data[cp0_pkg::STATUS_IM_HI:cp0_pkg::STATUS_IM_LO];
            end
            // eret wins over a same-cycle write of EXL
            if (eret_take) begin
                status_exl <= 1'b0;
            end
        end
    end

    // --------------------
    // cause
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ip_hw     <= '0;
            ip_sw     <= '0;
            cause_bd  <= 1'b0;
            cause_exc <= '0;
        end else begin
            // hw lines sampled every cycle
            ip_hw <= ext_int;
            if (exc_take) begin
                cause_bd  <= bd;
                cause_exc <= exc_code_eff;
            end else if (wr_cause) begin
                // sw interrupt bits IP1..IP0
                ip_sw <= mtc0_data[cp0_pkg::CAUSE_IP_LO+1:cp0_pkg::CAUSE_IP_LO];
            end
        end
    end

    // timer shares IP7 with the top external line
    assign cause_ip = {ip_hw[5] | timer_int, ip_hw[4:0], ip_sw};

    // --------------------
    // epc, badvaddr
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            epc <= '0;
        end else if (exc_take) begin
            // nested entry keeps the first epc
            if (!status_exl) begin
                epc <= bd ? (pc - 32'd4) : pc;
            end
        end else if (wr_epc) begin
            epc <= mtc0_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            badvaddr <= '0;
        end else if (exc_take && addr_err) begin
            badvaddr <= bad_vaddr;
        end
    end

    // --------------------
    // read mux
    // --------------------
    always_comb begin
        status_word = '0;
        // boot vectors always selected
        status_word[cp0_pkg::STATUS_BEV] = 1'b1;
        status_word[cp0_pkg::STATUS_IM_HI:cp0_pkg::STATUS_IM_LO] = status_im;
        status_word[cp0_pkg::STATUS_EXL] = status_exl;
        status_word[cp0_pkg::STATUS_IE]  = status_ie;
    end

    always_comb begin
        cause_word = '0;
        cause_word[cp0_pkg::CAUSE_BD] = cause_bd;
        cause_word[cp0_pkg::CAUSE_TI] = timer_int;
        cause_word[cp0_pkg::CAUSE_IP_HI:cp0_pkg::CAUSE_IP_LO]   = cause_ip;
        cause_word[cp0_pkg::CAUSE_EXC_HI:cp0_pkg::CAUSE_EXC_LO] = cause_exc;
    end

    always_comb begin
        case (cp0_addr)
            cp0_pkg::ADDR_BADVADDR: rd_data = badvaddr;
            cp0_pkg::ADDR_COUNT:    rd_data = count;
            cp0_pkg::ADDR_COMPARE:  rd_data = compare;
            cp0_pkg::ADDR_STATUS:   rd_data = status_word;
            cp0_pkg::ADDR_CAUSE:    rd_data = cause_word;
            cp0_pkg::ADDR_EPC:      rd_data = epc;
            // unmapped reads as zero
            default:                rd_data = '0;
        endcase
    end

endmodule

// File: hdl/cp0_exc_ctrl.sv
`timescale 1ns/100ps

module cp0_exc_ctrl (
    input  logic                valid,
    input  logic                exception,
    input  cp0_pkg::exc_code_t  exc_code,
    input  logic                eret,
    input  logic [1:0]          mftc0_op,
    input  logic                status_ie,
    input  logic                status_exl,
    input  logic [7:0]          status_im,
    input  logic [7:0]          cause_ip,
    input  cp0_pkg::cp0_word_t  epc,
    input  cp0_pkg::cp0_word_t  rd_data,
    output logic                exc_take,
    output cp0_pkg::exc_code_t  exc_code_eff,
    output logic                eret_take,
    output logic                mtc0_we,
    output logic                clr_stp_jmp,
    output cp0_pkg::cp0_word_t  cp0_res
);

    logic int_pend;
    logic is_mtc0;

    // --------------------
    // interrupt / exception
    // --------------------
    // masked pending line, globally enabled, not inside a handler
    assign int_pend = ((cause_ip & status_im) != 8'h00) && status_ie && !status_exl;

    // interrupt rides on the retiring instruction
    assign exc_take = valid && (exception || int_pend);

    // interrupt overrides the pipeline code
    assign exc_code_eff = int_pend ? cp0_pkg::EXC_INT : exc_code;

    // --------------------
    // eret / mtc0
    // --------------------
    // exception in the same slot squashes eret
    assign eret_take = valid && eret && !exc_take;

    // write bit of the op code
    assign is_mtc0 = (mftc0_op & cp0_pkg::MFTC0_MTC0) != 2'b00;

    // no register write from a faulting instruction
    assign mtc0_we = valid && is_mtc0 && !exc_take;

    // --------------------
    // result select
    // --------------------
    // stall, flush and jump together
    assign clr_stp_jmp = exc_take || eret_take;

    always_comb begin
        if (exc_take) begin
            cp0_res = cp0_pkg::EXC_VECTOR;
        end else if (eret_take) begin
            // return target
            cp0_res = epc;
        end else begin
            // plain mfc0 data
            cp0_res = rd_data;
        end
    end

endmodule

// File: hdl/cp0_top.sv
`timescale 1ns/100ps

module cp0_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid,
    input  logic                exception,
    input  logic                bd,
    input  cp0_pkg::exc_code_t  exc_code,
    input  cp0_pkg::cp0_addr_t  cp0_addr,
    input  cp0_pkg::cp0_word_t  mtc0_data,
    input  cp0_pkg::cp0_word_t  pc,
    input  cp0_pkg::cp0_word_t  bad_vaddr,
    input  logic                eret,
    input  logic [1:0]          mftc0_op,
    input  logic [5:0]          ext_int,
    output cp0_pkg::cp0_word_t  cp0_res,
    output logic                clr_stp_jmp
);

    // controller outputs
    logic                exc_take;
    cp0_pkg::exc_code_t  exc_code_eff;
    logic                eret_take;
    logic                mtc0_we;

    // register block state
    logic                status_ie;
    logic                status_exl;
    logic [7:0]          status_im;
    logic [7:0]          cause_ip;
    cp0_pkg::cp0_word_t  epc;
    cp0_pkg::cp0_word_t  rd_data;

    // timer
    cp0_pkg::cp0_word_t  count;
    cp0_pkg::cp0_word_t  compare;
    logic                timer_int;

    // --------------------
    // decision logic
    // --------------------
    cp0_exc_ctrl u_exc_ctrl (
        .valid        (valid),
        .exception    (exception),
        .exc_code     (exc_code),
        .eret         (eret),
        .mftc0_op     (mftc0_op),
        .status_ie    (status_ie),
        .status_exl   (status_exl),
        .status_im    (status_im),
        .cause_ip     (cause_ip),
        .epc          (epc),
        .rd_data      (rd_data),
        .exc_take     (exc_take),
        .exc_code_eff (exc_code_eff),
        .eret_take    (eret_take),
        .mtc0_we      (mtc0_we),
        .clr_stp_jmp  (clr_stp_jmp),
        .cp0_res      (cp0_res)
    );

    // --------------------
    // state
    // --------------------
    cp0_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .exc_take     (exc_take),
        .exc_code_eff (exc_code_eff),
        .eret_take    (eret_take),
        .mtc0_we      (mtc0_we),
        .bd           (bd),
        .pc           (pc),
        .bad_vaddr    (bad_vaddr),
        .cp0_addr     (cp0_addr),
        .mtc0_data    (mtc0_data),
        .ext_int      (ext_int),
        .timer_int    (timer_int),
        .count        (count),
        .compare      (compare),
        .status_ie    (status_ie),
        .status_exl   (status_exl),
        .status_im    (status_im),
        .cause_ip     (cause_ip),
        .epc          (epc),
        .rd_data      (rd_data)
    );

    // count / compare pair
    cp0_timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .mtc0_we   (mtc0_we),
        .cp0_addr  (cp0_addr),
        .mtc0_data (mtc0_data),
        .count     (count),
        .compare   (compare),
        .timer_int (timer_int)
    );

endmodule

// File: test/tb_cp0.sv
`timescale 1ns/100ps

module tb_cp0;

    // --------------------
    // dut ports
    // --------------------
    logic                clk;
    logic                rst;
    logic                valid;
    logic                exception;
    logic                bd;
    cp0_pkg::exc_code_t  exc_code;
    cp0_pkg::cp0_addr_t  cp0_addr;
    cp0_pkg::cp0_word_t  mtc0_data;
    cp0_pkg::cp0_word_t  pc;
    cp0_pkg::cp0_word_t  bad_vaddr;
    logic                eret;
    logic [1:0]          mftc0_op;
    logic [5:0]          ext_int;
    cp0_pkg::cp0_word_t  cp0_res;
    logic                clr_stp_jmp;

    // --------------------
    // reference model
    // --------------------
    logic                m_ie;
    logic                m_exl;
    logic [7:0]          m_im;
    logic [5:0]          m_ip_hw;
    logic [1:0]          m_ip_sw;
    logic                m_bd;
    cp0_pkg::exc_code_t  m_exc;
    cp0_pkg::cp0_word_t  m_epc;
    cp0_pkg::cp0_word_t  m_badvaddr;
    cp0_pkg::cp0_word_t  m_count;
    cp0_pkg::cp0_word_t  m_compare;
    logic                m_tick;
    logic                m_tint;

    // per-cycle decisions of the model
    logic                d_pend;
    logic                d_take;
    cp0_pkg::exc_code_t  d_code;
    logic                d_eret;
    logic                d_we;

    integer seed;
    integer errors;
    integer waited;
    integer i;
    string  test_name;

    cp0_top UUT (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .exception   (exception),
        .bd          (bd),
        .exc_code    (exc_code),
        .cp0_addr    (cp0_addr),
        .mtc0_data   (mtc0_data),
        .pc          (pc),
        .bad_vaddr   (bad_vaddr),
        .eret        (eret),
        .mftc0_op    (mftc0_op),
        .ext_int     (ext_int),
        .cp0_res     (cp0_res),
        .clr_stp_jmp (clr_stp_jmp)
    );

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_word(input string name, input cp0_pkg::cp0_word_t exp,
                              input cp0_pkg::cp0_word_t act);
        if (exp !== act) begin
            errors = errors + 1;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            errors = errors + 1;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // --------------------
    // model
    // --------------------
    function automatic logic [7:0] model_ip();
        // IP7 shared by ext line 5 and the timer
        return {m_ip_hw[5] | m_tint, m_ip_hw[4:0], m_ip_sw};
    endfunction

    function automatic cp0_pkg::cp0_word_t model_read(input cp0_pkg::cp0_addr_t addr);
        cp0_pkg::cp0_word_t w;
        w = '0;
        case (addr)
            cp0_pkg::ADDR_BADVADDR: w = m_badvaddr;
            cp0_pkg::ADDR_COUNT:    w = m_count;
            cp0_pkg::ADDR_COMPARE:  w = m_compare;
            cp0_pkg::ADDR_STATUS: begin
                w[cp0_pkg::STATUS_BEV] = 1'b1;
                w[cp0_pkg::STATUS_IM_HI:cp0_pkg::STATUS_IM_LO] = m_im;
                w[cp0_pkg::STATUS_EXL] = m_exl;
                w[cp0_pkg::STATUS_IE]  = m_ie;
            end
            cp0_pkg::ADDR_CAUSE: begin
                w[cp0_pkg::CAUSE_BD] = m_bd;
                w[cp0_pkg::CAUSE_TI] = m_tint;
                w[cp0_pkg::CAUSE_IP_HI:cp0_pkg::CAUSE_IP_LO]   = model_ip();
                w[cp0_pkg::CAUSE_EXC_HI:cp0_pkg::CAUSE_EXC_LO] = m_exc;
            end
            cp0_pkg::ADDR_EPC:      w = m_epc;
            default:                w = '0;
        endcase
        return w;
    endfunction

    task automatic model_reset();
        m_ie       = 1'b0;
        m_exl      = 1'b0;
        m_im       = '0;
        m_ip_hw    = '0;
        m_ip_sw    = '0;
        m_bd       = 1'b0;
        m_exc      = '0;
        m_epc      = '0;
        m_badvaddr = '0;
        m_count    = '0;
        m_compare  = '0;
        m_tick     = 1'b0;
        m_tint     = 1'b0;
    endtask

    // decisions from model state and the inputs now on the ports
    task automatic model_decide();
        d_pend = ((model_ip() & m_im) != 8'h00) && m_ie && !m_exl;
        d_take = valid && (exception || d_pend);
        d_code = d_pend ? cp0_pkg::EXC_INT : exc_code;
        d_eret = valid && eret && !d_take;
        d_we   = valid && mftc0_op[1] && !d_take;
    endtask

    task automatic model_update();
        model_decide();
        // compare match sees the old count
        if (d_we && cp0_addr == cp0_pkg::ADDR_COMPARE) begin
            m_compare = mtc0_data;
            m_tint    = 1'b0;
        end else if (m_count == m_compare && m_compare != '0) begin
            m_tint = 1'b1;
        end
        if (d_we && cp0_addr == cp0_pkg::ADDR_COUNT) begin
            m_count = mtc0_data;
            m_tick  = 1'b0;
        end else begin
            if (m_tick) begin
                m_count = m_count + 32'd1;
            end
            m_tick = ~m_tick;
        end
        // epc needs EXL before the status update
        if (d_take) begin
            if (!m_exl) begin
                m_epc = bd ? (pc - 32'd4) : pc;
            end
        end else if (d_we && cp0_addr == cp0_pkg::ADDR_EPC) begin
            m_epc = mtc0_data;
        end
        if (d_take && (d_code == cp0_pkg::EXC_ADEL || d_code == cp0_pkg::EXC_ADES)) begin
            m_badvaddr = bad_vaddr;
        end
        if (d_take) begin
            m_bd  = bd;
            m_exc = d_code;
        end else if (d_we && cp0_addr == cp0_pkg::ADDR_CAUSE) begin
            m_ip_sw = mtc0_data[cp0_pkg::CAUSE_IP_LO+1:cp0_pkg::CAUSE_IP_LO];
        end
        m_ip_hw = ext_int;
        if (d_take) begin
            m_exl = 1'b1;
        end else begin
            if (d_we && cp0_addr == cp0_pkg::ADDR_STATUS) begin
                m_ie  = mtc0_data[cp0_pkg::STATUS_IE];
                m_exl = mtc0_data[cp0_pkg::STATUS_EXL];
                m_im  = mtc0_data[cp0_pkg::STATUS_IM_HI:cp0_pkg::STATUS_IM_LO];
            end
            if (d_eret) begin
                m_exl = 1'b0;
            end
        end
    endtask

    // --------------------
    // cycle helpers
    // --------------------
    // combinational outputs sampled mid-cycle
    task automatic check_outputs();
        cp0_pkg::cp0_word_t exp_res;
        model_decide();
        if (d_take) begin
            exp_res = cp0_pkg::EXC_VECTOR;
        end else if (d_eret) begin
            exp_res = m_epc;
        end else begin
            exp_res = model_read(cp0_addr);
        end
        check_flag({test_name, " flush"}, d_take || d_eret, clr_stp_jmp);
        check_word({test_name, " result"}, exp_res, cp0_res);
    endtask

    task automatic next_cycle();
        @(negedge clk);
        check_outputs();
        @(posedge clk);
        model_update();
    endtask

    function automatic cp0_pkg::cp0_addr_t pick_addr(input logic [2:0] idx);
        case (idx)
            3'd0:    return cp0_pkg::ADDR_BADVADDR;
            3'd1:    return cp0_pkg::ADDR_COUNT;
            3'd2:    return cp0_pkg::ADDR_COMPARE;
            3'd3:    return cp0_pkg::ADDR_STATUS;
            3'd4:    return cp0_pkg::ADDR_CAUSE;
            3'd5:    return cp0_pkg::ADDR_EPC;
            // unmapped slot
            3'd6:    return 8'd16;
            default: return cp0_pkg::ADDR_STATUS;
        endcase
    endfunction

    task automatic drive_op(input logic [1:0] op, input cp0_pkg::cp0_addr_t addr,
                            input cp0_pkg::cp0_word_t data);
        valid     <= 1'b1;
        exception <= 1'b0;
        eret      <= 1'b0;
        ext_int   <= '0;
        mftc0_op  <= op;
        cp0_addr  <= addr;
        mtc0_data <= data;
    endtask

    task automatic drive_random(input logic allow_exc, input logic allow_eret,
                                input logic allow_int);
        cp0_pkg::cp0_word_t r;
        r = $random(seed);
        valid     <= r[0] | r[1];
        exception <= allow_exc && (r[4:2] == 3'd0);
        bd        <= r[5];
        // bias toward address errors
        exc_code  <= r[6] ? cp0_pkg::EXC_ADEL : (r[7] ? cp0_pkg::EXC_ADES : r[12:8]);
        eret      <= allow_eret && (r[15:13] == 3'd0);
        mftc0_op  <= r[17:16];
        cp0_addr  <= pick_addr(r[20:18]);
        ext_int   <= (allow_int && r[23:21] == 3'd0) ? r[29:24] : 6'd0;
        mtc0_data <= $random(seed);
        pc        <= $random(seed) & 32'hffff_fffc;
        bad_vaddr <= $random(seed);
    endtask

    // --------------------
    // stimulus
    // --------------------
    initial begin
        seed      = 32'h7a33;
        errors    = 0;
        waited    = 0;
        test_name = "reset values";
        rst       <= 1'b1;
        valid     <= 1'b0;
        exception <= 1'b0;
        bd        <= 1'b0;
        exc_code  <= '0;
        cp0_addr  <= '0;
        mtc0_data <= '0;
        pc        <= '0;
        bad_vaddr <= '0;
        eret      <= 1'b0;
        mftc0_op  <= '0;
        ext_int   <= '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        model_reset();

        // idle reads of every register
        for (i = 0; i < 7; i = i + 1) begin
            drive_op(cp0_pkg::MFTC0_MFC0, pick_addr(i[2:0]), '0);
            valid <= 1'b0;
            next_cycle();
        end

        test_name = "mtc0 mfc0";
        repeat (300) begin
            drive_random(1'b0, 1'b0, 1'b0);
            next_cycle();
        end

        test_name = "exception entry";
        repeat (400) begin
            drive_random(1'b1, 1'b0, 1'b0);
            next_cycle();
        end

        test_name = "eret";
        // read address other than EPC so the return select shows
        drive_op(cp0_pkg::MFTC0_MFC0, cp0_pkg::ADDR_COUNT, '0);
        eret <= 1'b1;
        next_cycle();
        // exception beats eret in one slot
        drive_op(cp0_pkg::MFTC0_MFC0, cp0_pkg::ADDR_STATUS, '0);
        exception <= 1'b1;
        eret      <= 1'b1;
        next_cycle();
        repeat (400) begin
            drive_random(1'b1, 1'b1, 1'b0);
            next_cycle();
        end

        test_name = "interrupts";
        drive_op(cp0_pkg::MFTC0_MTC0, cp0_pkg::ADDR_STATUS, 32'h0000_ff01);
        next_cycle();
        repeat (400) begin
            drive_random(1'b0, 1'b1, 1'b1);
            next_cycle();
        end

        // second write lands even if the first was taken by an interrupt
        test_name = "timer";
        repeat (2) begin
            drive_op(cp0_pkg::MFTC0_MTC0, cp0_pkg::ADDR_STATUS, '0);
            next_cycle();
        end
        drive_op(cp0_pkg::MFTC0_MTC0, cp0_pkg::ADDR_COUNT, '0);
        next_cycle();
        drive_op(cp0_pkg::MFTC0_MTC0, cp0_pkg::ADDR_COMPARE, 32'd8);
        next_cycle();
        waited = 0;
        while (!m_tint && waited < 64) begin
            drive_op(cp0_pkg::MFTC0_MFC0, cp0_pkg::ADDR_CAUSE, '0);
            next_cycle();
            waited = waited + 1;
        end
        if (!m_tint) begin
            errors = errors + 1;
            $display("timeout: the timer interrupt never set after the compare write");
        end
        drive_op(cp0_pkg::MFTC0_MFC0, cp0_pkg::ADDR_CAUSE, '0);
        @(negedge clk);
        check_flag("timer ti set", 1'b1, cp0_res[cp0_pkg::CAUSE_TI]);
        check_flag("timer ip7 set", 1'b1, cp0_res[cp0_pkg::CAUSE_IP_HI]);
        @(posedge clk);
        model_update();
        // compare write acks the timer
        drive_op(cp0_pkg::MFTC0_MTC0, cp0_pkg::ADDR_COMPARE, '0);
        next_cycle();
        drive_op(cp0_pkg::MFTC0_MFC0, cp0_pkg::ADDR_CAUSE, '0);
        @(negedge clk);
        check_flag("timer ti clear", 1'b0, cp0_res[cp0_pkg::CAUSE_TI]);
        check_flag("timer ip7 clear", 1'b0, cp0_res[cp0_pkg::CAUSE_IP_HI]);
        check_outputs();

        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: tb.f
hdl/cp0_pkg.sv
hdl/cp0_timer.sv
hdl/cp0_regs.sv
hdl/cp0_exc_ctrl.sv
hdl/cp0_top.sv
test/tb_cp0.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the CP0 testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_cp0 -f tb.f \
    --Mdir obj_dir -o sim_cp0

out=$(./obj_dir/sim_cp0)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
else
    exit 1
fi
